//--- common/isa_pkg.sv
// Instruction set definitions shared by the execute stage and its testbench.
// Opcodes, branch kinds, operand sources and register index constants.
`default_nettype none

package isa_pkg;

	localparam int REG_IDX_WIDTH = 5;

	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

	// Reading this register yields the PC of the instruction
	localparam reg_idx_t REG_PC = 5'd31;

	// Lane operations; MUL is the only long-latency one
	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,
		OP_SUB   = 3'd1,
		OP_AND   = 3'd2,
		OP_OR    = 3'd3,
		OP_XOR   = 3'd4,
		OP_EQUAL = 3'd5,
		OP_SILT  = 3'd6,
		OP_MUL   = 3'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		BRANCH_NONE          = 3'd0,
		BRANCH_ZERO          = 3'd1,
		BRANCH_NOT_ZERO      = 3'd2,
		BRANCH_ALL           = 3'd3,
		BRANCH_NOT_ALL       = 3'd4,
		BRANCH_ALWAYS        = 3'd5,
		BRANCH_CALL_OFFSET   = 3'd6,
		BRANCH_CALL_REGISTER = 3'd7
	} branch_kind_t;

	typedef enum logic [1:0] {
		OP2_SRC_SCALAR2   = 2'd0,
		OP2_SRC_VECTOR2   = 2'd1,
		OP2_SRC_IMMEDIATE = 2'd2
	} op2_src_t;

	typedef enum logic {
		MASK_SRC_SCALAR2  = 1'b0,
		MASK_SRC_ALL_ONES = 1'b1
	} mask_src_t;

endpackage

`default_nettype wire

//--- common/exec_pkg.sv
// Datapath types for the execute stage: lane count, vectors and the
// packed structs passed between the bypass network, ALU, multiplier and output.
`default_nettype none

package exec_pkg;

	import isa_pkg::*;

	localparam int NUM_LANES = 4;
	localparam int WORD_WIDTH = 32;
	localparam int STRAND_WIDTH = 2;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef word_t [NUM_LANES-1:0] vector_t;
	typedef logic [NUM_LANES-1:0] lane_mask_t;
	typedef logic [STRAND_WIDTH-1:0] strand_t;

	// Decoded instruction as it arrives from issue
	typedef struct packed {
		logic         valid;
		strand_t      strand;
		word_t        pc;
		alu_op_t      alu_op;
		logic         op1_is_vector;
		op2_src_t     op2_src;
		mask_src_t    mask_src;
		word_t        immediate;
		branch_kind_t branch_kind;
		word_t        branch_offset;
		logic         predicted_taken;
		reg_idx_t     writeback_reg;
		logic         scalar_wb;
		logic         vector_wb;
		reg_idx_t     scalar_sel1;
		reg_idx_t     scalar_sel2;
		reg_idx_t     vector_sel1;
		reg_idx_t     vector_sel2;
	} issue_t;

	typedef struct packed {
		word_t   scalar1;
		word_t   scalar2;
		vector_t vector1;
		vector_t vector2;
	} regs_t;

	// A younger result that has not reached the register file yet
	typedef struct packed {
		reg_idx_t   writeback_reg;
		logic       scalar_wb;
		logic       vector_wb;
		vector_t    value;
		lane_mask_t mask;
	} bypass_t;

	typedef struct packed {
		vector_t    op1;
		vector_t    op2;
		word_t      scalar1;
		lane_mask_t mask;
	} operands_t;

	typedef struct packed {
		logic       valid;
		strand_t    strand;
		word_t      pc;
		reg_idx_t   writeback_reg;
		logic       scalar_wb;
		logic       vector_wb;
		lane_mask_t mask;
		vector_t    result;
	} stage_result_t;

endpackage

`default_nettype wire

//--- source/operand_bypass.sv
// Operand selection for the execute stage. Forwards scalar and per-lane vector
// values from younger results, then forms op1, op2 and the lane mask.
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
	import isa_pkg::*, exec_pkg::*;
(
	input  issue_t    issue_i,
	input  regs_t     regs_i,
	input  bypass_t   ex_bypass_i,
	input  bypass_t   ma_bypass_i,
	input  bypass_t   wb_bypass_i,
	output operands_t operands_o
);

	word_t   scalar1;
	word_t   scalar2;
	vector_t vector1;
	vector_t vector2;

	function automatic logic scalar_hit(input bypass_t src, input reg_idx_t sel);
		return src.scalar_wb && src.writeback_reg == sel;
	endfunction

	function automatic logic lane_hit(input bypass_t src, input reg_idx_t sel, input int lane);
		return src.vector_wb && src.writeback_reg == sel && src.mask[lane];
	endfunction

	// Nearest producer wins; scalar values live in lane 0
	function automatic word_t forward_scalar(input reg_idx_t sel, input word_t rf_value);
		if (sel == REG_PC)
			return issue_i.pc;
		else if (scalar_hit(ex_bypass_i, sel))
			return ex_bypass_i.value[0];
		else if (scalar_hit(ma_bypass_i, sel))
			return ma_bypass_i.value[0];
		else if (scalar_hit(wb_bypass_i, sel))
			return wb_bypass_i.value[0];
		else
			return rf_value;
	endfunction

	// Each lane picks its own source, since writers may have been partially masked
	function automatic vector_t forward_vector(input reg_idx_t sel, input vector_t rf_value);
		vector_t value;
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			if (lane_hit(ex_bypass_i, sel, lane))
				value[lane] = ex_bypass_i.value[lane];
			else if (lane_hit(ma_bypass_i, sel, lane))
				value[lane] = ma_bypass_i.value[lane];
			else if (lane_hit(wb_bypass_i, sel, lane))
				value[lane] = wb_bypass_i.value[lane];
			else
				value[lane] = rf_value[lane];
		end
		return value;
	endfunction

	assign scalar1 = forward_scalar(issue_i.scalar_sel1, regs_i.scalar1);
	assign scalar2 = forward_scalar(issue_i.scalar_sel2, regs_i.scalar2);
	assign vector1 = forward_vector(issue_i.vector_sel1, regs_i.vector1);
	assign vector2 = forward_vector(issue_i.vector_sel2, regs_i.vector2);

	always_comb
	begin
		operands_o.scalar1 = scalar1;
		operands_o.op1 = issue_i.op1_is_vector ? vector1 : {NUM_LANES{scalar1}};

		case (issue_i.op2_src)
			OP2_SRC_SCALAR2:   operands_o.op2 = {NUM_LANES{scalar2}};
			OP2_SRC_VECTOR2:   operands_o.op2 = vector2;
			OP2_SRC_IMMEDIATE: operands_o.op2 = {NUM_LANES{issue_i.immediate}};
			default:           operands_o.op2 = '0;
		endcase

		if (issue_i.mask_src == MASK_SRC_ALL_ONES)
			operands_o.mask = '1;
		else
			operands_o.mask = scalar2[NUM_LANES-1:0];
	end

endmodule

`default_nettype wire

//--- source/branch_resolve.sv
// Branch resolution in the issue cycle. Evaluates the branch condition and
// target, and flags a misprediction against the predicted direction.
`timescale 1ns/1ps
`default_nettype none

module branch_resolve
	import isa_pkg::*, exec_pkg::*;
(
	input  issue_t    issue_i,
	input  operands_t operands_i,
	input  vector_t   alu_result_i,
	output logic      taken_o,
	output word_t     target_o,
	output logic      rollback_o
);

	word_t op1_lane0;
	logic  pc_write;

	assign op1_lane0 = operands_i.op1[0];

	// Arithmetic result written to the PC acts as a computed jump
	assign pc_write = issue_i.alu_op != OP_MUL && issue_i.scalar_wb
		&& issue_i.writeback_reg == REG_PC;

	always_comb
	begin
		if (pc_write)
		begin
			taken_o = 1'b1;
			target_o = alu_result_i[0];
		end
		else
		begin
			case (issue_i.branch_kind)
				BRANCH_ZERO:          taken_o = op1_lane0 == '0;
				BRANCH_NOT_ZERO:      taken_o = op1_lane0 != '0;
				BRANCH_ALL:           taken_o = &op1_lane0[NUM_LANES-1:0];
				BRANCH_NOT_ALL:       taken_o = !(&op1_lane0[NUM_LANES-1:0]);
				BRANCH_ALWAYS:        taken_o = 1'b1;
				BRANCH_CALL_OFFSET:   taken_o = 1'b1;
				BRANCH_CALL_REGISTER: taken_o = 1'b1;
				default:              taken_o = 1'b0;
			endcase

			if (issue_i.branch_kind == BRANCH_CALL_REGISTER)
				target_o = op1_lane0;
			else
				target_o = issue_i.pc + issue_i.branch_offset;
		end
	end

	// Caller clears valid when the issue slot is squashed
	assign rollback_o = issue_i.valid && (taken_o != issue_i.predicted_taken);

endmodule

`default_nettype wire

//--- lane_alu/lane_alu.sv
// Single-cycle integer lane unit. Every lane computes the same operation;
// compares return one bit per lane packed into the low bits of lane 0.
`timescale 1ns/1ps
`default_nettype none

module lane_alu
	import isa_pkg::*, exec_pkg::*;
(
	input  alu_op_t   op_i,
	input  operands_t operands_i,
	output vector_t   result_o
);

	vector_t    lane_value;
	vector_t    packed_compare;
	lane_mask_t equal_bits;
	lane_mask_t less_bits;
	logic       is_compare;

	always_comb
	begin
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			equal_bits[lane] = operands_i.op1[lane] == operands_i.op2[lane];
			less_bits[lane] = $signed(operands_i.op1[lane]) < $signed(operands_i.op2[lane]);

			case (op_i)
				OP_ADD:  lane_value[lane] = operands_i.op1[lane] + operands_i.op2[lane];
				OP_SUB:  lane_value[lane] = operands_i.op1[lane] - operands_i.op2[lane];
				OP_AND:  lane_value[lane] = operands_i.op1[lane] & operands_i.op2[lane];
				OP_OR:   lane_value[lane] = operands_i.op1[lane] | operands_i.op2[lane];
				OP_XOR:  lane_value[lane] = operands_i.op1[lane] ^ operands_i.op2[lane];
				// Compares and MUL are produced elsewhere
				default: lane_value[lane] = '0;
			endcase
		end
	end

	// One result bit per lane, upper bits zero
	always_comb
	begin
		packed_compare = '0;
		if (op_i == OP_EQUAL)
			packed_compare[0][NUM_LANES-1:0] = equal_bits;
		else
			packed_compare[0][NUM_LANES-1:0] = less_bits;
	end

	assign is_compare = op_i == OP_EQUAL || op_i == OP_SILT;
	assign result_o = is_compare ? packed_compare : lane_value;

endmodule

`default_nettype wire

//--- lane_alu/lane_multiplier.sv
// Long-latency lane multiply. The low product words and the instruction tag
// travel through MUL_STAGES registers; any stage can be squashed in flight.
`timescale 1ns/1ps
`default_nettype none

module lane_multiplier
	import isa_pkg::*, exec_pkg::*;
#(
	parameter int MUL_STAGES = 3
)
(
	input  logic                clk,
	input  logic                reset,
	input  issue_t              issue_i,
	input  operands_t           operands_i,
	input  logic [MUL_STAGES:0] squash_i,
	output stage_result_t       result_o
);

	logic          mul_issue;
	stage_result_t capture;

	// Per-stage control, with reset
	logic [MUL_STAGES:1] valid_q;
	logic [MUL_STAGES:1] scalar_wb_q;
	logic [MUL_STAGES:1] vector_wb_q;

	// Per-stage tag and products
	stage_result_t payload_q [1:MUL_STAGES];

	assign mul_issue = issue_i.valid && issue_i.alu_op == OP_MUL && !squash_i[0];

	always_comb
	begin
		capture.valid = mul_issue;
		capture.strand = issue_i.strand;
		capture.pc = issue_i.pc;
		capture.writeback_reg = issue_i.writeback_reg;
		capture.scalar_wb = issue_i.scalar_wb;
		capture.vector_wb = issue_i.vector_wb;
		capture.mask = operands_i.mask;
		// Only the low word of each product is kept
		for (int lane = 0; lane < NUM_LANES; lane++)
			capture.result[lane] = operands_i.op1[lane] * operands_i.op2[lane];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			scalar_wb_q <= '0;
			vector_wb_q <= '0;
		end
		else
		begin
			valid_q[1] <= mul_issue;
			scalar_wb_q[1] <= mul_issue & issue_i.scalar_wb;
			vector_wb_q[1] <= mul_issue & issue_i.vector_wb;
			// Squash bit k kills whatever currently sits in stage k
			for (int k = 1; k < MUL_STAGES; k++)
			begin
				valid_q[k + 1] <= valid_q[k] & ~squash_i[k];
				scalar_wb_q[k + 1] <= scalar_wb_q[k] & ~squash_i[k];
				vector_wb_q[k + 1] <= vector_wb_q[k] & ~squash_i[k];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		payload_q[1] <= capture;
		for (int k = 1; k < MUL_STAGES; k++)
			payload_q[k + 1] <= payload_q[k];
	end

	// Last stage may still be killed in the cycle it merges
	always_comb
	begin
		result_o = payload_q[MUL_STAGES];
		result_o.valid = valid_q[MUL_STAGES] & ~squash_i[MUL_STAGES];
		result_o.scalar_wb = scalar_wb_q[MUL_STAGES] & ~squash_i[MUL_STAGES];
		result_o.vector_wb = vector_wb_q[MUL_STAGES] & ~squash_i[MUL_STAGES];
	end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// Execute stage top level. Bypasses operands, runs the lane ALU, multiplier
// and branch unit, merges the single-cycle and multiply paths into one register.
`timescale 1ns/1ps
`default_nettype none

module execute_stage
	import isa_pkg::*, exec_pkg::*;
#(
	parameter int MUL_STAGES = 3
)
(
	input  logic                clk,
	input  logic                reset,
	input  issue_t              issue_i,
	input  regs_t               regs_i,
	input  bypass_t             ma_bypass_i,
	input  bypass_t             wb_bypass_i,
	input  logic [MUL_STAGES:0] squash_i,
	output stage_result_t       result_o,
	output logic                rollback_o,
	output word_t               rollback_pc_o
);

	issue_t        issue_live;
	bypass_t       ex_bypass;
	operands_t     operands;
	vector_t       alu_result;
	stage_result_t mul_result;
	stage_result_t result_nxt;
	logic          taken;
	word_t         target;
	logic          is_call;

	// Issue slot with the squash applied
	always_comb
	begin
		issue_live = issue_i;
		issue_live.valid = issue_i.valid & ~squash_i[0];
	end

	// Our own output register is the closest forwarding source
	always_comb
	begin
		ex_bypass.writeback_reg = result_o.writeback_reg;
		ex_bypass.scalar_wb = result_o.scalar_wb;
		ex_bypass.vector_wb = result_o.vector_wb;
		ex_bypass.value = result_o.result;
		ex_bypass.mask = result_o.mask;
	end

	operand_bypass u_operand_bypass (
		.issue_i     (issue_i),
		.regs_i      (regs_i),
		.ex_bypass_i (ex_bypass),
		.ma_bypass_i (ma_bypass_i),
		.wb_bypass_i (wb_bypass_i),
		.operands_o  (operands)
	);

	lane_alu u_lane_alu (
		.op_i       (issue_i.alu_op),
		.operands_i (operands),
		.result_o   (alu_result)
	);

	lane_multiplier #(
		.MUL_STAGES (MUL_STAGES)
	) u_lane_multiplier (
		.clk        (clk),
		.reset      (reset),
		.issue_i    (issue_i),
		.operands_i (operands),
		.squash_i   (squash_i),
		.result_o   (mul_result)
	);

	branch_resolve u_branch_resolve (
		.issue_i      (issue_live),
		.operands_i   (operands),
		.alu_result_i (alu_result),
		.taken_o      (taken),
		.target_o     (target),
		.rollback_o   (rollback_o)
	);

	assign rollback_pc_o = taken ? target : issue_i.pc;

	assign is_call = issue_i.branch_kind == BRANCH_CALL_OFFSET
		|| issue_i.branch_kind == BRANCH_CALL_REGISTER;

	// Multiply wins a collision; the scheduler keeps that from happening
	always_comb
	begin
		result_nxt = '0;
		if (mul_result.valid)
			result_nxt = mul_result;
		else if (issue_live.valid && issue_live.alu_op != OP_MUL)
		begin
			result_nxt.valid = 1'b1;
			result_nxt.strand = issue_live.strand;
			result_nxt.pc = issue_live.pc;
			result_nxt.writeback_reg = issue_live.writeback_reg;
			result_nxt.scalar_wb = issue_live.scalar_wb;
			result_nxt.vector_wb = issue_live.vector_wb;
			result_nxt.mask = operands.mask;
			// Return address for calls
			if (is_call)
				result_nxt.result[0] = issue_live.pc;
			else
				result_nxt.result = alu_result;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result_o <= '0;
		else
			result_o <= result_nxt;
	end

endmodule

`default_nettype wire

//--- testbench/execute_stage_sva.sv
// Concurrent checks on the execute stage, bound into every execute_stage instance.
// Covers the idle state after reset, result collisions and rollback qualification.
`timescale 1ns/1ps
`default_nettype none

module execute_stage_sva
	import isa_pkg::*, exec_pkg::*;
#(
	parameter int MUL_STAGES = 3
)
(
	input logic                clk,
	input logic                reset,
	input issue_t              issue_i,
	input logic [MUL_STAGES:0] squash_i,
	input stage_result_t       result_o,
	input logic                rollback_o,
	input logic                mul_valid_i,
	input logic                issue_valid_i
);

	logic issued_since_reset;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			issued_since_reset <= 1'b0;
		else if (issue_i.valid)
			issued_since_reset <= 1'b1;
	end

	// Output stays idle until something has been issued
	idle_after_reset: assert property (@(posedge clk) disable iff (reset)
		!issued_since_reset |-> !result_o.valid && !result_o.scalar_wb && !result_o.vector_wb)
		else $error("Result became active before any issue");

	no_collision: assert property (@(posedge clk) disable iff (reset)
		!(mul_valid_i && issue_valid_i && issue_i.alu_op != OP_MUL))
		else $error("Multiply result collided with a single-cycle issue");

	rollback_needs_issue: assert property (@(posedge clk) disable iff (reset)
		rollback_o |-> issue_i.valid && !squash_i[0])
		else $error("Rollback raised without a live issue");

endmodule

bind execute_stage execute_stage_sva #(
	.MUL_STAGES (MUL_STAGES)
) u_execute_stage_sva (
	.clk           (clk),
	.reset         (reset),
	.issue_i       (issue_i),
	.squash_i      (squash_i),
	.result_o      (result_o),
	.rollback_o    (rollback_o),
	.mul_valid_i   (mul_result.valid),
	.issue_valid_i (issue_live.valid)
);

`default_nettype wire

//--- testbench/execute_stage_tb.sv
// Testbench for the execute stage. Random decoded issues, bypass sources and squashes
// are checked against a reference model; bound assertions cover the control rules.
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb
	import isa_pkg::*, exec_pkg::*;
();

	localparam int MUL_STAGES = 3;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ISSUES = 700;
	localparam int DRAIN_CYCLES = 8;
	// Reset plus issues plus drain, with margin
	localparam int TIMEOUT_CYCLES = 2000;

	typedef struct {
		int            due;
		logic          is_mul;
		stage_result_t value;
	} expect_t;

	logic                clk;
	logic                reset;
	issue_t              issue;
	regs_t               regs;
	bypass_t             ma_bypass;
	bypass_t             wb_bypass;
	logic [MUL_STAGES:0] squash;
	stage_result_t       result;
	logic                rollback;
	word_t               rollback_pc;

	expect_t       expect_q[$];
	stage_result_t model_out;
	bypass_t       srcs[3];
	word_t         rf_scalar[32];
	vector_t       rf_vector[32];
	logic [31:0]   rng_state;
	logic          exp_rollback;
	word_t         exp_rollback_pc;
	int            cyc;
	int            cycle_count;

	execute_stage #(
		.MUL_STAGES (MUL_STAGES)
	) DUT (
		.clk           (clk),
		.reset         (reset),
		.issue_i       (issue),
		.regs_i        (regs),
		.ma_bypass_i   (ma_bypass),
		.wb_bypass_i   (wb_bypass),
		.squash_i      (squash),
		.result_o      (result),
		.rollback_o    (rollback),
		.rollback_pc_o (rollback_pc)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] rand_word();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Small values make zero and all-ones branch conditions likely
	function automatic word_t rand_value();
		logic [31:0] r;
		r = rand_word();
		return r[0] ? (rand_word() & 32'h0000_000f) : rand_word();
	endfunction

	// Registers 0..7 collide often, 15 maps onto the PC register
	function automatic reg_idx_t pick_reg(input logic [3:0] x);
		return (x == 4'hf) ? REG_PC : {2'b00, x[2:0]};
	endfunction

	function automatic bypass_t random_bypass();
		bypass_t     b;
		logic [31:0] r;
		r = rand_word();
		b.writeback_reg = pick_reg(r[3:0]);
		b.scalar_wb = r[4];
		b.vector_wb = r[5];
		b.mask = r[9:6];
		for (int lane = 0; lane < NUM_LANES; lane++)
			b.value[lane] = rand_value();
		return b;
	endfunction

	function automatic word_t ref_scalar(input reg_idx_t sel);
		if (sel == REG_PC)
			return issue.pc;
		for (int s = 0; s < 3; s++)
			if (srcs[s].scalar_wb && srcs[s].writeback_reg == sel)
				return srcs[s].value[0];
		return rf_scalar[sel];
	endfunction

	// Walk from farthest to nearest so the nearest source overwrites
	function automatic vector_t ref_vector(input reg_idx_t sel);
		vector_t v;
		v = rf_vector[sel];
		for (int lane = 0; lane < NUM_LANES; lane++)
			for (int s = 2; s >= 0; s--)
				if (srcs[s].vector_wb && srcs[s].writeback_reg == sel && srcs[s].mask[lane])
					v[lane] = srcs[s].value[lane];
		return v;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		assert (got === expected)
		else
		begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_output();
		stage_result_t exp;
		exp = '0;
		for (int i = expect_q.size() - 1; i >= 0; i--)
		begin
			if (expect_q[i].due == cyc)
			begin
				exp = expect_q[i].value;
				expect_q.delete(i);
			end
		end
		check_value("result_o.valid", 128'(result.valid), 128'(exp.valid));
		check_value("result_o.strand", 128'(result.strand), 128'(exp.strand));
		check_value("result_o.pc", 128'(result.pc), 128'(exp.pc));
		check_value("result_o.writeback_reg", 128'(result.writeback_reg),
			128'(exp.writeback_reg));
		check_value("result_o.scalar_wb", 128'(result.scalar_wb), 128'(exp.scalar_wb));
		check_value("result_o.vector_wb", 128'(result.vector_wb), 128'(exp.vector_wb));
		check_value("result_o.mask", 128'(result.mask), 128'(exp.mask));
		check_value("result_o.result", 128'(result.result), 128'(exp.result));
		model_out = exp;
	endtask

	task automatic check_rollback();
		check_value("rollback_o", 128'(rollback), 128'(exp_rollback));
		check_value("rollback_pc_o", 128'(rollback_pc), 128'(exp_rollback_pc));
	endtask

	task automatic drive_cycle(input logic allow_issue);
		logic [31:0]   r;
		logic [31:0]   r2;
		word_t         s1;
		word_t         s2;
		word_t         target;
		vector_t       op1;
		vector_t       op2;
		vector_t       alu;
		lane_mask_t    mask;
		logic          taken;
		logic          busy;
		logic          is_mul;
		stage_result_t exp;
		int            k;

		rf_scalar[rand_word() & 32'h7] = rand_value();
		rf_vector[rand_word() & 32'h7][rand_word() & 32'h3] = rand_value();
		ma_bypass = random_bypass();
		wb_bypass = random_bypass();
		srcs[0] = '{model_out.writeback_reg, model_out.scalar_wb, model_out.vector_wb,
			model_out.result, model_out.mask};
		srcs[1] = ma_bypass;
		srcs[2] = wb_bypass;

		// Occasional squash of the issue slot or of one multiply stage
		r = rand_word();
		squash = '0;
		if (r[4:2] == 3'd0)
		begin
			k = int'(r[1:0]);
			squash[k] = 1'b1;
			for (int i = expect_q.size() - 1; i >= 0; i--)
				if (k > 0 && expect_q[i].is_mul && expect_q[i].due == cyc + MUL_STAGES + 1 - k)
					expect_q.delete(i);
		end
		busy = 1'b0;
		foreach (expect_q[i])
			if (expect_q[i].due == cyc + 1)
				busy = 1'b1;

		r = rand_word();
		r2 = rand_word();
		issue = '0;
		issue.valid = allow_issue && r[2:0] != 3'd0;
		issue.strand = r[4:3];
		issue.pc = rand_word() & 32'hffff_fffc;
		issue.alu_op = alu_op_t'(r[7:5]);
		issue.op1_is_vector = r[8];
		issue.op2_src = (r[10:9] == 2'd3) ? OP2_SRC_VECTOR2 : op2_src_t'(r[10:9]);
		issue.mask_src = mask_src_t'(r[11]);
		issue.immediate = rand_value();
		issue.branch_kind = r[15] ? branch_kind_t'(r[14:12]) : BRANCH_NONE;
		issue.branch_offset = rand_word();
		issue.predicted_taken = r[16];
		issue.writeback_reg = pick_reg(r[20:17]);
		issue.scalar_wb = r[21];
		issue.vector_wb = r[22];
		issue.scalar_sel1 = pick_reg(r[26:23]);
		issue.scalar_sel2 = pick_reg(r[30:27]);
		issue.vector_sel1 = pick_reg(r2[3:0]);
		issue.vector_sel2 = pick_reg(r2[7:4]);
		// A multiply leaves the pipe next cycle, so only another multiply may issue
		if (busy && issue.valid)
			issue.alu_op = OP_MUL;
		if (issue.alu_op == OP_MUL)
			issue.branch_kind = BRANCH_NONE;

		regs.scalar1 = rf_scalar[issue.scalar_sel1];
		regs.scalar2 = rf_scalar[issue.scalar_sel2];
		regs.vector1 = rf_vector[issue.vector_sel1];
		regs.vector2 = rf_vector[issue.vector_sel2];

		s1 = ref_scalar(issue.scalar_sel1);
		s2 = ref_scalar(issue.scalar_sel2);
		op1 = issue.op1_is_vector ? ref_vector(issue.vector_sel1) : {NUM_LANES{s1}};
		case (issue.op2_src)
			OP2_SRC_VECTOR2:   op2 = ref_vector(issue.vector_sel2);
			OP2_SRC_IMMEDIATE: op2 = {NUM_LANES{issue.immediate}};
			default:           op2 = {NUM_LANES{s2}};
		endcase
		mask = (issue.mask_src == MASK_SRC_ALL_ONES) ? '1 : s2[NUM_LANES-1:0];

		alu = '0;
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			case (issue.alu_op)
				OP_ADD:   alu[lane] = op1[lane] + op2[lane];
				OP_SUB:   alu[lane] = op1[lane] - op2[lane];
				OP_AND:   alu[lane] = op1[lane] & op2[lane];
				OP_OR:    alu[lane] = op1[lane] | op2[lane];
				OP_XOR:   alu[lane] = op1[lane] ^ op2[lane];
				OP_EQUAL: alu[0][lane] = op1[lane] == op2[lane];
				OP_SILT:  alu[0][lane] = $signed(op1[lane]) < $signed(op2[lane]);
				default:  alu[lane] = op1[lane] * op2[lane];
			endcase
		end

		is_mul = issue.alu_op == OP_MUL;
		taken = issue.branch_kind inside {BRANCH_ALWAYS, BRANCH_CALL_OFFSET,
			BRANCH_CALL_REGISTER};
		if (issue.branch_kind == BRANCH_ZERO)
			taken = op1[0] == '0;
		if (issue.branch_kind == BRANCH_NOT_ZERO)
			taken = op1[0] != '0;
		if (issue.branch_kind == BRANCH_ALL)
			taken = op1[0][NUM_LANES-1:0] == '1;
		if (issue.branch_kind == BRANCH_NOT_ALL)
			taken = op1[0][NUM_LANES-1:0] != '1;
		if (issue.branch_kind == BRANCH_CALL_REGISTER)
			target = op1[0];
		else
			target = issue.pc + issue.branch_offset;
		// Computed jump through the PC register
		if (!is_mul && issue.scalar_wb && issue.writeback_reg == REG_PC)
		begin
			taken = 1'b1;
			target = alu[0];
		end
		exp_rollback = issue.valid && !squash[0] && taken != issue.predicted_taken;
		exp_rollback_pc = taken ? target : issue.pc;

		if (issue.valid && !squash[0])
		begin
			exp = '0;
			exp.valid = 1'b1;
			exp.strand = issue.strand;
			exp.pc = issue.pc;
			exp.writeback_reg = issue.writeback_reg;
			exp.scalar_wb = issue.scalar_wb;
			exp.vector_wb = issue.vector_wb;
			exp.mask = mask;
			if (issue.branch_kind inside {BRANCH_CALL_OFFSET, BRANCH_CALL_REGISTER})
				exp.result[0] = issue.pc;
			else
				exp.result = alu;
			expect_q.push_back('{cyc + (is_mul ? MUL_STAGES + 1 : 1), is_mul, exp});
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		issue = '0;
		regs = '0;
		ma_bypass = '0;
		wb_bypass = '0;
		squash = '0;
		model_out = '0;
		rng_state = 32'd81;
		cycle_count = 0;
		exp_rollback = 1'b0;
		exp_rollback_pc = '0;
		for (int i = 0; i < 32; i++)
		begin
			rf_scalar[i] = rand_value();
			for (int lane = 0; lane < NUM_LANES; lane++)
				rf_vector[i][lane] = rand_value();
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0;

		for (cyc = 0; cyc < NUM_ISSUES + DRAIN_CYCLES; cyc++)
		begin
			@(posedge clk);
			#1 check_output();
			#1 drive_cycle(cyc < NUM_ISSUES);
			#1 check_rollback();
		end

		if (expect_q.size() != 0)
		begin
			$display("%0d expected results never appeared", expect_q.size());
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
common/isa_pkg.sv
common/exec_pkg.sv
source/operand_bypass.sv
source/branch_resolve.sv
lane_alu/lane_alu.sv
lane_alu/lane_multiplier.sv
source/execute_stage.sv
testbench/execute_stage_sva.sv
testbench/execute_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module execute_stage_tb \
	-Mdir obj_dir -o sim_exec
./obj_dir/sim_exec > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
